//--- flist.f
bist_pkg.sv
mbist_engine.sv
sa_lbist_engine.sv
result_checker.sv
bist_top.sv
tb_bist_top.sv

//--- run_sim.sh
#!/bin/sh
# build the BIST testbench with Verilator, run it and scan the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_bist_top -o sim_bist

./obj_dir/sim_bist | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- tb_bist_top.sv
// self-checking testbench for bist_top, runs MBIST clean and faulty and LBIST with random eNVM data
`timescale 1ns/1ps
`default_nettype none

module tb_bist_top;

    localparam int size         = 8;
    localparam int sa_depth     = 12;
    localparam int bg_depth     = 8;
    localparam int mbist_cycles = 3 * size * bg_depth;           // 192
    localparam int lbist_cycles = sa_depth * (size + 1) + size;  // 116
    // two runs of each engine, about three times over, 2000 in all
    localparam int timeout_cycles = 3 * (2 * mbist_cycles + 2 * lbist_cycles) + 152;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic                       test_mode;
    logic                       bist_mode;
    bist_pkg::weight_t          envm_weight;
    bist_pkg::act_t             envm_activation;
    bist_pkg::psum_t            envm_partial_sum_in;
    bist_pkg::psum_t            envm_answer;
    bist_pkg::psum_t [size-1:0] partial_sum_flat = '0;

    logic                         acc_wr_en;
    bist_pkg::lane_addr_t         acc_wr_addr;
    bist_pkg::psum_t [size-1:0]   acc_wr_data;
    bist_pkg::lane_addr_t         acc_rd_addr;
    logic                         scan_en;
    logic                         diagnosis_start_en;
    logic                         detection_en;
    bist_pkg::pattern_idx_t       test_counter;
    bist_pkg::weight_t [size-1:0] weight_in_test_flat;
    bist_pkg::act_t [size-1:0]    activation_in_test_flat;
    bist_pkg::psum_t [size-1:0]   partial_sum_test_flat;
    bist_pkg::lane_mask_t         compared_results;
    logic                         test_done;
    logic                         mbist_fail;

    bist_pkg::psum_t [size-1:0] acc_mem [size];   // accumulator contents per address
    bist_pkg::psum_t [size-1:0] lbist_psum = '0;  // read data fed to the DUT during LBIST
    logic                       lbist_drive;
    logic                       fault_en;
    bist_pkg::lane_addr_t       fault_addr;
    bist_pkg::lane_addr_t       fault_lane;
    logic [4:0]                 fault_bit;        // stuck-at-1 bit in the faulty lane

    logic [31:0] rng_state     = 32'd57164;
    int          cycles        = 0;
    int          errors        = 0;
    int          scan_cycles   = 0; // running totals of scan_en and detection_en
    int          detect_cycles = 0;

    bist_top UUT (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start                  (start),
        .test_mode              (test_mode),
        .bist_mode              (bist_mode),
        .envm_weight            (envm_weight),
        .envm_activation        (envm_activation),
        .envm_partial_sum_in    (envm_partial_sum_in),
        .envm_answer            (envm_answer),
        .partial_sum_flat       (partial_sum_flat),
        .acc_wr_en              (acc_wr_en),
        .acc_wr_addr            (acc_wr_addr),
        .acc_wr_data            (acc_wr_data),
        .acc_rd_addr            (acc_rd_addr),
        .scan_en                (scan_en),
        .diagnosis_start_en     (diagnosis_start_en),
        .detection_en           (detection_en),
        .test_counter           (test_counter),
        .weight_in_test_flat    (weight_in_test_flat),
        .activation_in_test_flat(activation_in_test_flat),
        .partial_sum_test_flat  (partial_sum_test_flat),
        .compared_results       (compared_results),
        .test_done              (test_done),
        .mbist_fail             (mbist_fail)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: no final result after %0d clock cycles", cycles);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by timeout");
        end
    end

    // enable cycles counted on every clock, including those around the checked window
    always @(negedge clk) begin
        scan_cycles   <= scan_cycles + int'(scan_en);
        detect_cycles <= detect_cycles + int'(detection_en);
    end

    // registered-read accumulator, optional stuck-at-1 on one lane of one address
    always @(posedge clk) begin : acc_model
        bist_pkg::psum_t [size-1:0] rd_data;
        rd_data = acc_mem[acc_rd_addr];
        if (fault_en && acc_rd_addr == fault_addr) begin
            rd_data[fault_lane][fault_bit] = 1'b1;
        end
        if (!rst_n) begin
            for (int a = 0; a < size; a++) begin
                for (int l = 0; l < size; l++) begin
                    acc_mem[a][l] <= bist_pkg::psum_t'((a * 16 + l) * 40503);
                end
            end
            partial_sum_flat <= '0;
        end else begin
            if (acc_wr_en) acc_mem[acc_wr_addr] <= acc_wr_data;
            if (lbist_drive) partial_sum_flat <= lbist_psum;
            else             partial_sum_flat <= rd_data;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // March data backgrounds in test order
    function automatic bist_pkg::psum_t background_value(input int idx);
        case (idx)
            0:       return 19'h00000;
            1:       return 19'h7FFFF;
            2:       return 19'h55555;
            3:       return 19'h2AAAA;
            4:       return 19'h33333;
            5:       return 19'h4CCCC;
            6:       return 19'h0F0F0;
            default: return 19'h70F0F;
        endcase
    endfunction

    task automatic abort_run();
        errors++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_lanes(input bist_pkg::lane_mask_t got, input bist_pkg::lane_mask_t exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_psum(input bist_pkg::psum_t got, input bist_pkg::psum_t exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input bist_pkg::pattern_idx_t got, input bist_pkg::pattern_idx_t exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic start_run(input logic mode);
        @(posedge clk);
        start     <= 1'b1;
        test_mode <= 1'b1;
        bist_mode <= mode;
    endtask

    // status holds while start is high, clears one cycle after it drops
    task automatic release_start();
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag(test_done, 1'b1, "test_done while engine still in final state");
        @(negedge clk);
        check_flag(test_done, 1'b0, "test_done after start released");
        check_flag(mbist_fail, 1'b0, "mbist_fail after start released");
    endtask

    task automatic run_mbist(input logic with_fault);
        int                   end_cycle;
        int                   fail_bg;
        int                   idx;
        int                   bg;
        int                   addr;
        int                   phase;
        bist_pkg::psum_t      bg_val;
        bist_pkg::lane_mask_t exp_mask;
        fail_bg     = -1;
        fault_en    = with_fault;
        lbist_drive = 1'b0;
        if (with_fault) begin
            fault_addr = bist_pkg::lane_addr_t'(next_random());
            fault_lane = bist_pkg::lane_addr_t'(next_random());
            fault_bit  = 5'(next_random() % 19);
            for (int b = bg_depth - 1; b >= 0; b--) begin
                bg_val = background_value(b);
                if (bg_val[fault_bit] == 1'b0) fail_bg = b; // first background with a 0 there
            end
        end
        if (fail_bg < 0) end_cycle = mbist_cycles + 1;
        else             end_cycle = 3 * (fail_bg * size + int'(fault_addr)) + 4;
        start_run(1'b0);
        for (int c = 1; c <= end_cycle; c++) begin
            @(posedge clk);
            @(negedge clk);
            idx    = (c - 1) / 3;
            bg     = idx / size;
            addr   = idx % size;
            phase  = (c - 1) % 3;   // write, read, check
            bg_val = background_value(bg);
            if (c < end_cycle) begin
                check_flag(acc_wr_en, phase == 0, "acc_wr_en");
                if (phase == 0) begin
                    check_idx(bist_pkg::pattern_idx_t'(acc_wr_addr),
                              bist_pkg::pattern_idx_t'(addr), "acc_wr_addr");
                    for (int l = 0; l < size; l++) begin
                        check_psum(acc_wr_data[l], bg_val, "acc_wr_data lane");
                    end
                end
                if (phase == 1) begin
                    check_idx(bist_pkg::pattern_idx_t'(acc_rd_addr),
                              bist_pkg::pattern_idx_t'(addr), "acc_rd_addr");
                end
                if (phase == 2) begin
                    exp_mask = '0;
                    if (with_fault && addr == int'(fault_addr) && bg_val[fault_bit] == 1'b0) begin
                        exp_mask[fault_lane] = 1'b1;
                    end
                    check_lanes(compared_results, exp_mask, "compared_results in check cycle");
                end
            end
            check_flag(test_done, c == end_cycle, "mbist test_done");
            check_flag(mbist_fail, with_fault && c == end_cycle, "mbist_fail");
        end
        fault_en = 1'b0;
    endtask

    task automatic run_lbist();
        int                   p;
        int                   s;
        int                   scan_base;
        int                   detect_base;
        logic                 in_shift;
        logic                 in_final;
        logic                 exp_valid;
        logic [31:0]          rnd;
        bist_pkg::psum_t      exp_reg;
        bist_pkg::lane_mask_t exp_mask;
        scan_base    = scan_cycles;
        detect_base  = detect_cycles;
        exp_valid    = 1'b0;
        exp_reg      = '0;
        lbist_drive  = 1'b1;
        start_run(1'b1);
        for (int c = 1; c <= lbist_cycles + 1; c++) begin
            @(posedge clk);
            envm_weight         <= bist_pkg::weight_t'(next_random());
            envm_activation     <= bist_pkg::act_t'(next_random());
            envm_partial_sum_in <= bist_pkg::psum_t'(next_random());
            envm_answer         <= bist_pkg::psum_t'(next_random());
            @(negedge clk);
            p            = (c - 1) / (size + 1);
            s            = (c - 1) % (size + 1);
            in_shift     = (c <= sa_depth * (size + 1)) && (s < size);
            in_final     = (c > sa_depth * (size + 1)) && (c <= lbist_cycles);
            check_flag(scan_en, in_shift || in_final, "scan_en");
            check_flag(detection_en, in_final, "detection_en");
            check_flag(diagnosis_start_en, (in_shift && p > 0) || in_final, "diagnosis_start_en");
            for (int l = 0; l < size; l++) begin
                check_psum(bist_pkg::psum_t'(weight_in_test_flat[l]),
                           in_shift ? bist_pkg::psum_t'(envm_weight) : '0, "weight test lane");
                check_psum(bist_pkg::psum_t'(activation_in_test_flat[l]),
                           in_shift ? bist_pkg::psum_t'(envm_activation) : '0, "act test lane");
                check_psum(partial_sum_test_flat[l],
                           in_shift ? envm_partial_sum_in : '0, "psum test lane");
            end
            if (in_shift) check_idx(test_counter, bist_pkg::pattern_idx_t'(p), "test_counter");
            if (exp_valid) begin
                for (int l = 0; l < size; l++) begin
                    exp_mask[l] = (partial_sum_flat[l] != exp_reg);
                end
                check_lanes(compared_results, exp_mask, "compared_results during lbist");
            end
            check_flag(test_done, c == lbist_cycles + 1, "lbist test_done");
            check_flag(mbist_fail, 1'b0, "mbist_fail during lbist");
            if (in_shift) begin
                exp_reg   = envm_answer;  // latched at the end of this shift cycle
                exp_valid = 1'b1;
            end
            for (int l = 0; l < size; l++) begin
                rnd = next_random();
                lbist_psum[l] = rnd[0] ? exp_reg : bist_pkg::psum_t'(rnd >> 8); // mix hits and misses
            end
        end
        check_flag(scan_cycles - scan_base == size * sa_depth + size, 1'b1,
                   "scan_en cycle count of 104");
        check_flag(detect_cycles - detect_base == size, 1'b1, "detection_en cycle count of 8");
    endtask

    initial begin
        rst_n               = 1'b0;
        start               = 1'b0;
        test_mode           = 1'b0;
        bist_mode           = 1'b0;
        envm_weight         = '0;
        envm_activation     = '0;
        envm_partial_sum_in = '0;
        envm_answer         = '0;
        lbist_drive         = 1'b0;
        fault_en            = 1'b0;
        fault_addr          = '0;
        fault_lane          = '0;
        fault_bit           = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(test_done, 1'b0, "test_done after reset");
        check_flag(mbist_fail, 1'b0, "mbist_fail after reset");
        check_flag(acc_wr_en, 1'b0, "acc_wr_en after reset");
        check_flag(scan_en, 1'b0, "scan_en after reset");
        check_flag(detection_en, 1'b0, "detection_en after reset");
        check_flag(diagnosis_start_en, 1'b0, "diagnosis_start_en after reset");

        run_mbist(1'b0);
        release_start();
        run_lbist();      // other mode straight from idle
        release_start();
        run_mbist(1'b1);
        release_start();
        run_lbist();
        release_start();

        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bist_top.sv
// BIST controller top, decodes start and mode and wires the MBIST and LBIST engines to the checker
`timescale 1ns/1ps
`default_nettype none

module bist_top #(
    parameter int systolic_size       = 8,
    parameter int sa_pattern_depth    = 12,
    parameter int mbist_pattern_depth = 8
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   start,
    input  wire logic                                   test_mode,
    input  wire logic                                   bist_mode, // 0 mbist, 1 lbist
    input  wire bist_pkg::weight_t                      envm_weight,
    input  wire bist_pkg::act_t                         envm_activation,
    input  wire bist_pkg::psum_t                        envm_partial_sum_in,
    input  wire bist_pkg::psum_t                        envm_answer,
    input  wire bist_pkg::psum_t [systolic_size-1:0]    partial_sum_flat,
    output logic                                        acc_wr_en,
    output bist_pkg::lane_addr_t                        acc_wr_addr,
    output bist_pkg::psum_t [systolic_size-1:0]         acc_wr_data,
    output bist_pkg::lane_addr_t                        acc_rd_addr,
    output logic                                        scan_en,
    output logic                                        diagnosis_start_en,
    output logic                                        detection_en,
    output bist_pkg::pattern_idx_t                      test_counter,
    output bist_pkg::weight_t [systolic_size-1:0]       weight_in_test_flat,
    output bist_pkg::act_t [systolic_size-1:0]          activation_in_test_flat,
    output bist_pkg::psum_t [systolic_size-1:0]         partial_sum_test_flat,
    output bist_pkg::lane_mask_t                        compared_results,
    output logic                                        test_done,
    output logic                                        mbist_fail
);

    logic            mbist_go;
    logic            lbist_go;
    logic            mbist_exp_load;
    bist_pkg::psum_t mbist_exp_data;
    logic            mbist_done;
    logic            mbist_fail_int;
    logic            lbist_exp_load;
    logic            lbist_done;

    assign mbist_go = start && test_mode && !bist_mode;
    assign lbist_go = start && test_mode && bist_mode;

    mbist_engine #(
        .systolic_size      (systolic_size),
        .mbist_pattern_depth(mbist_pattern_depth)
    ) u_mbist (
        .clk             (clk),
        .rst_n           (rst_n),
        .go              (mbist_go),
        .compared_results(compared_results),
        .acc_wr_en       (acc_wr_en),
        .acc_wr_addr     (acc_wr_addr),
        .acc_rd_addr     (acc_rd_addr),
        .acc_wr_data     (acc_wr_data),
        .exp_load        (mbist_exp_load),
        .exp_data        (mbist_exp_data),
        .done            (mbist_done),
        .fail            (mbist_fail_int)
    );

    sa_lbist_engine #(
        .systolic_size   (systolic_size),
        .sa_pattern_depth(sa_pattern_depth)
    ) u_lbist (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .go                     (lbist_go),
        .envm_weight            (envm_weight),
        .envm_activation        (envm_activation),
        .envm_partial_sum_in    (envm_partial_sum_in),
        .scan_en                (scan_en),
        .diagnosis_start_en     (diagnosis_start_en),
        .detection_en           (detection_en),
        .exp_load               (lbist_exp_load),
        .done                   (lbist_done),
        .test_counter           (test_counter),
        .weight_in_test_flat    (weight_in_test_flat),
        .activation_in_test_flat(activation_in_test_flat),
        .partial_sum_test_flat  (partial_sum_test_flat)
    );

    result_checker #(
        .systolic_size(systolic_size)
    ) u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .mbist_exp_load  (mbist_exp_load),
        .mbist_exp_data  (mbist_exp_data),
        .lbist_exp_load  (lbist_exp_load),
        .envm_answer     (envm_answer),
        .partial_sum_flat(partial_sum_flat),
        .mbist_done      (mbist_done),
        .mbist_fail_in   (mbist_fail_int),
        .lbist_done      (lbist_done),
        .compared_results(compared_results),
        .test_done       (test_done),
        .mbist_fail      (mbist_fail)
    );

endmodule

`default_nettype wire

//--- result_checker.sv
// shared expected-value register, per-lane accumulator compare and merged test status
`timescale 1ns/1ps
`default_nettype none

module result_checker #(
    parameter int systolic_size = 8
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   mbist_exp_load,
    input  wire bist_pkg::psum_t                        mbist_exp_data,
    input  wire logic                                   lbist_exp_load,
    input  wire bist_pkg::psum_t                        envm_answer,
    input  wire bist_pkg::psum_t [systolic_size-1:0]    partial_sum_flat,
    input  wire logic                                   mbist_done,
    input  wire logic                                   mbist_fail_in,
    input  wire logic                                   lbist_done,
    output bist_pkg::lane_mask_t                        compared_results,
    output logic                                        test_done,
    output logic                                        mbist_fail
);

    bist_pkg::psum_t exp_reg;

    always_ff @(posedge clk) begin
        if (mbist_exp_load) begin
            exp_reg <= mbist_exp_data; // memory engine wins
        end else if (lbist_exp_load) begin
            exp_reg <= envm_answer;
        end
    end

    always_comb begin
        compared_results = '0;
        for (int i = 0; i < systolic_size; i++) begin
            compared_results[i] = (partial_sum_flat[i] != exp_reg);
        end
    end

    assign test_done  = mbist_done || mbist_fail_in || lbist_done;
    assign mbist_fail = mbist_fail_in;

    // both engines share exp_reg, only one may run at a time
    a_no_load_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mbist_exp_load && lbist_exp_load)
    );

endmodule

`default_nettype wire

//--- sa_lbist_engine.sv
// stuck-at scan sequencer, shifts eNVM patterns into the array, captures, then shifts out for diagnosis
`timescale 1ns/1ps
`default_nettype none

module sa_lbist_engine #(
    parameter int systolic_size    = 8,
    parameter int sa_pattern_depth = 12
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   go,
    input  wire bist_pkg::weight_t                      envm_weight,
    input  wire bist_pkg::act_t                         envm_activation,
    input  wire bist_pkg::psum_t                        envm_partial_sum_in,
    output logic                                        scan_en,
    output logic                                        diagnosis_start_en,
    output logic                                        detection_en,
    output logic                                        exp_load,
    output logic                                        done,
    output bist_pkg::pattern_idx_t                      test_counter,
    output bist_pkg::weight_t [systolic_size-1:0]       weight_in_test_flat,
    output bist_pkg::act_t [systolic_size-1:0]          activation_in_test_flat,
    output bist_pkg::psum_t [systolic_size-1:0]         partial_sum_test_flat
);

    bist_pkg::lbist_state_t state, next_state;
    bist_pkg::lane_addr_t   shift_cnt;
    bist_pkg::pattern_idx_t pattern_cnt;

    logic shift_last;
    logic pattern_last;

    assign shift_last   = (shift_cnt == bist_pkg::lane_addr_t'(systolic_size - 1));
    assign pattern_last = (pattern_cnt == bist_pkg::pattern_idx_t'(sa_pattern_depth - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bist_pkg::l_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bist_pkg::l_idle:        if (go) next_state = bist_pkg::l_shift;
            bist_pkg::l_shift:       if (shift_last) next_state = bist_pkg::l_capture;
            bist_pkg::l_capture: begin
                if (pattern_last) next_state = bist_pkg::l_final_shift;
                else              next_state = bist_pkg::l_shift;
            end
            bist_pkg::l_final_shift: if (shift_last) next_state = bist_pkg::l_done;
            bist_pkg::l_done:        if (!go) next_state = bist_pkg::l_idle;
            default:                 next_state = bist_pkg::l_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_cnt   <= '0;
            pattern_cnt <= '0;
        end else begin
            case (state)
                bist_pkg::l_idle: begin
                    shift_cnt   <= '0;
                    pattern_cnt <= '0;
                end
                bist_pkg::l_shift,
                bist_pkg::l_final_shift: shift_cnt <= shift_cnt + 1'b1; // wraps to 0 after 7
                bist_pkg::l_capture: begin
                    shift_cnt <= '0;
                    if (!pattern_last) pattern_cnt <= pattern_cnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // broadcast the current eNVM pattern to all lanes while shifting
    always_comb begin
        for (int i = 0; i < systolic_size; i++) begin
            weight_in_test_flat[i]     = '0;
            activation_in_test_flat[i] = '0;
            partial_sum_test_flat[i]   = '0;
            if (state == bist_pkg::l_shift) begin
                weight_in_test_flat[i]     = envm_weight;
                activation_in_test_flat[i] = envm_activation;
                partial_sum_test_flat[i]   = envm_partial_sum_in;
            end
        end
    end

    assign scan_en      = (state == bist_pkg::l_shift) || (state == bist_pkg::l_final_shift);
    assign detection_en = (state == bist_pkg::l_final_shift);
    assign exp_load     = (state == bist_pkg::l_shift); // latch envm_answer every shift cycle
    assign test_counter = pattern_cnt;
    assign done         = (state == bist_pkg::l_done);

    // pattern 0 has no previous result to shift out
    assign diagnosis_start_en = ((state == bist_pkg::l_shift) && (pattern_cnt != '0)) ||
                                (state == bist_pkg::l_final_shift);

    // final shift-out is a full scan window ending in done
    a_final_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(detection_en) |-> (detection_en && scan_en) [*systolic_size] ##1 done
    );

endmodule

`default_nettype wire

//--- mbist_engine.sv
// March-style accumulator test, write/read/check per address for every background, halts on mismatch
`timescale 1ns/1ps
`default_nettype none

module mbist_engine #(
    parameter int systolic_size       = 8,
    parameter int mbist_pattern_depth = 8
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   go,
    input  wire bist_pkg::lane_mask_t                   compared_results,
    output logic                                        acc_wr_en,
    output bist_pkg::lane_addr_t                        acc_wr_addr,
    output bist_pkg::lane_addr_t                        acc_rd_addr,
    output bist_pkg::psum_t [systolic_size-1:0]         acc_wr_data,
    output logic                                        exp_load,
    output bist_pkg::psum_t                             exp_data,
    output logic                                        done,
    output logic                                        fail
);

    bist_pkg::mbist_state_t state, next_state;
    bist_pkg::lane_addr_t   addr;
    bist_pkg::pattern_idx_t bg_idx;
    bist_pkg::psum_t        bg_data;

    logic last_addr;
    logic last_bg;
    logic mismatch;

    assign last_addr = (addr == bist_pkg::lane_addr_t'(systolic_size - 1));
    assign last_bg   = (bg_idx == bist_pkg::pattern_idx_t'(mbist_pattern_depth - 1));
    assign mismatch  = |compared_results;
    assign bg_data   = bist_pkg::mbist_background[bg_idx[2:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bist_pkg::m_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bist_pkg::m_idle:  if (go) next_state = bist_pkg::m_write;
            bist_pkg::m_write: next_state = bist_pkg::m_read;
            bist_pkg::m_read:  next_state = bist_pkg::m_check; // read data lands next cycle
            bist_pkg::m_check: begin
                if (mismatch) begin
                    next_state = bist_pkg::m_fail;
                end else if (last_addr && last_bg) begin
                    next_state = bist_pkg::m_pass;
                end else begin
                    next_state = bist_pkg::m_write;
                end
            end
            bist_pkg::m_pass,
            bist_pkg::m_fail:  if (!go) next_state = bist_pkg::m_idle; // hold status until start drops
            default:           next_state = bist_pkg::m_idle;
        endcase
    end

    // address and background counters, frozen on a mismatch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr   <= '0;
            bg_idx <= '0;
        end else if (state == bist_pkg::m_idle && go) begin
            addr   <= '0;
            bg_idx <= '0;
        end else if (state == bist_pkg::m_check && !mismatch) begin
            if (last_addr) begin
                addr <= '0;
                if (!last_bg) bg_idx <= bg_idx + 1'b1;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < systolic_size; i++) begin
            acc_wr_data[i] = bg_data; // same background on every lane
        end
    end

    assign acc_wr_en   = (state == bist_pkg::m_write);
    assign acc_wr_addr = addr;
    assign acc_rd_addr = addr;
    assign exp_load    = (state == bist_pkg::m_read);
    assign exp_data    = bg_data;
    assign done        = (state == bist_pkg::m_pass);
    assign fail        = (state == bist_pkg::m_fail);

    // an unknown compare result would let a bad read slip through as a pass
    a_check_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == bist_pkg::m_check) |-> !$isunknown(compared_results)
    );

endmodule

`default_nettype wire

//--- bist_pkg.sv
// shared widths, types, FSM encodings and the MBIST background table for the BIST controller
`default_nettype none

package bist_pkg;

    localparam int weight_w = 8;
    localparam int act_w    = 8;
    localparam int psum_w   = weight_w + act_w + 3; // 19 bits, room for 8 accumulated products

    typedef logic [weight_w-1:0] weight_t;
    typedef logic [act_w-1:0]    act_t;
    typedef logic [psum_w-1:0]   psum_t;

    typedef logic [7:0] lane_mask_t;   // one mismatch flag per accumulator lane
    typedef logic [2:0] lane_addr_t;   // accumulator address or scan shift count
    typedef logic [3:0] pattern_idx_t; // eNVM pattern or background index

    typedef enum logic [2:0] {
        m_idle,
        m_write,
        m_read,
        m_check,
        m_pass,
        m_fail
    } mbist_state_t;

    typedef enum logic [2:0] {
        l_idle,
        l_shift,
        l_capture,
        l_final_shift,
        l_done
    } lbist_state_t;

    // data backgrounds, each pair is a complement of the previous one
    localparam psum_t mbist_background [0:7] = '{
        19'h00000,
        19'h7FFFF,
        19'h55555, // checkerboard
        19'h2AAAA,
        19'h33333, // double stripes
        19'h4CCCC,
        19'h0F0F0, // nibble stripes
        19'h70F0F
    };

endpackage

`default_nettype wire
